// ==== files.f ====
src/shell_pkg.sv
src/wake_ctrl.sv
src/scr_key_mgr.sv
src/mem_arbiter.sv
src/scr_ram.sv
src/core_shell_top.sv
verif/tb_clk_gen.sv
verif/tb_core_shell.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory shell testbench with Verilator.
# Exit status is 0 only when the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f files.f \
  --top-module tb_core_shell -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build returned status $status"
  exit 1
fi

out=$(./obj_dir/Vtb_core_shell)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation binary returned status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

// ==== src/core_shell_top.sv ====
// Memory shell top level. The core sits outside and drives the fetch
// and data ports; both share one scrambled RAM, data first.
// Requests stall while a new scramble key is outstanding.
`timescale 1ns/1ns
`default_nettype none

module core_shell_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Instruction fetch port
  input  logic                             instr_req_i,
  input  shell_pkg::addr_t                 instr_addr_i,
  output logic                             instr_gnt_o,
  output logic                             instr_rvalid_o,
  output shell_pkg::word_t                 instr_rdata_o,
  // Data port
  input  logic                             data_req_i,
  input  logic                             data_we_i,
  input  shell_pkg::be_t                   data_be_i,
  input  shell_pkg::addr_t                 data_addr_i,
  input  shell_pkg::word_t                 data_wdata_i,
  output logic                             data_gnt_o,
  output logic                             data_rvalid_o,
  output shell_pkg::word_t                 data_rdata_o,
  // Scrambling
  input  logic                             inval_i,
  input  logic                             scramble_key_valid_i,
  input  shell_pkg::key_t                  scramble_key_i,
  input  shell_pkg::nonce_t                scramble_nonce_i,
  output logic                             scramble_req_o,
  // Wake sources
  input  logic                             core_busy_i,
  input  logic                             debug_req_i,
  input  logic                             irq_software_i,
  input  logic                             irq_timer_i,
  input  logic                             irq_external_i,
  input  logic [shell_pkg::IRQ_FAST_W-1:0] irq_fast_i,
  input  logic                             irq_nm_i,
  output logic                             core_sleep_o
);

  logic                 key_valid;
  shell_pkg::key_t      key;
  shell_pkg::nonce_t    nonce;
  logic                 ram_req;
  logic                 ram_we;
  shell_pkg::be_t       ram_be;
  shell_pkg::ram_addr_t ram_addr;
  shell_pkg::word_t     ram_wdata;
  shell_pkg::word_t     ram_rdata;

  ///////////////////////////////////////////////////
  // Sleep and key control
  ///////////////////////////////////////////////////

  wake_ctrl u_wake_ctrl (
    .clk_i,
    .rst_ni,
    .core_busy_i,
    .debug_req_i,
    .irq_software_i,
    .irq_timer_i,
    .irq_external_i,
    .irq_fast_i,
    .irq_nm_i,
    .core_sleep_o
  );

  scr_key_mgr u_scr_key_mgr (
    .clk_i,
    .rst_ni,
    .inval_i,
    .scramble_key_valid_i,
    .scramble_key_i,
    .scramble_nonce_i,
    .scramble_req_o,
    .key_valid_o (key_valid),
    .key_o       (key),
    .nonce_o     (nonce)
  );

  ///////////////////////////////////////////////////
  // Memory path
  ///////////////////////////////////////////////////

  mem_arbiter u_mem_arbiter (
    .clk_i,
    .rst_ni,
    .key_valid_i (key_valid),
    .instr_req_i,
    .instr_addr_i,
    .instr_gnt_o,
    .instr_rvalid_o,
    .instr_rdata_o,
    .data_req_i,
    .data_we_i,
    .data_be_i,
    .data_addr_i,
    .data_wdata_i,
    .data_gnt_o,
    .data_rvalid_o,
    .data_rdata_o,
    .ram_req_o   (ram_req),
    .ram_we_o    (ram_we),
    .ram_be_o    (ram_be),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .ram_rdata_i (ram_rdata)
  );

  scr_ram u_scr_ram (
    .clk_i,
    .req_i   (ram_req),
    .we_i    (ram_we),
    .be_i    (ram_be),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .key_i   (key),
    .nonce_i (nonce),
    .rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
// Fixed-priority arbiter, data port ahead of instruction fetch.
// Nothing is granted while the scramble key is invalid; requests just wait.
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                key_valid_i,
  // Instruction fetch port
  input  logic                instr_req_i,
  input  shell_pkg::addr_t    instr_addr_i,
  output logic                instr_gnt_o,
  output logic                instr_rvalid_o,
  output shell_pkg::word_t    instr_rdata_o,
  // Data port
  input  logic                data_req_i,
  input  logic                data_we_i,
  input  shell_pkg::be_t      data_be_i,
  input  shell_pkg::addr_t    data_addr_i,
  input  shell_pkg::word_t    data_wdata_i,
  output logic                data_gnt_o,
  output logic                data_rvalid_o,
  output shell_pkg::word_t    data_rdata_o,
  // RAM side
  output logic                ram_req_o,
  output logic                ram_we_o,
  output shell_pkg::be_t      ram_be_o,
  output shell_pkg::ram_addr_t ram_addr_o,
  output shell_pkg::word_t    ram_wdata_o,
  input  shell_pkg::word_t    ram_rdata_i
);

  logic data_gnt;
  logic instr_gnt;
  logic data_rvalid_q;
  logic instr_rvalid_q;

  ///////////////////////////////////////////////////
  // Grant
  ///////////////////////////////////////////////////

  assign data_gnt  = key_valid_i & data_req_i;
  assign instr_gnt = key_valid_i & instr_req_i & ~data_req_i;

  assign data_gnt_o  = data_gnt;
  assign instr_gnt_o = instr_gnt;

  // Fetches are full-word reads
  assign ram_req_o   = data_gnt | instr_gnt;
  assign ram_we_o    = data_gnt & data_we_i;
  assign ram_be_o    = data_gnt ? data_be_i : '1;
  assign ram_addr_o  = data_gnt ? data_addr_i[shell_pkg::RAM_AW+1:2]
                                : instr_addr_i[shell_pkg::RAM_AW+1:2];
  assign ram_wdata_o = data_wdata_i;

  ///////////////////////////////////////////////////
  // Response routing
  ///////////////////////////////////////////////////

  // Owner of last cycle's access gets the response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_rvalid_q  <= 1'b0;
      instr_rvalid_q <= 1'b0;
    end else begin
      data_rvalid_q  <= data_gnt;
      instr_rvalid_q <= instr_gnt;
    end
  end

  assign data_rvalid_o  = data_rvalid_q;
  assign instr_rvalid_o = instr_rvalid_q;

  // RAM output only holds meaning alongside rvalid
  assign data_rdata_o  = ram_rdata_i;
  assign instr_rdata_o = ram_rdata_i;

endmodule

`default_nettype wire

// ==== src/scr_key_mgr.sv ====
// Scramble key request/valid handling.
// Request rises after an invalidate pulse and holds until a fresh key shows.
// Key and nonce are captured whenever scramble_key_valid_i is high.
`timescale 1ns/1ns
`default_nettype none

module scr_key_mgr (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              inval_i,
  input  logic              scramble_key_valid_i,
  input  shell_pkg::key_t   scramble_key_i,
  input  shell_pkg::nonce_t scramble_nonce_i,
  output logic              scramble_req_o,
  output logic              key_valid_o,
  output shell_pkg::key_t   key_o,
  output shell_pkg::nonce_t nonce_o
);

  shell_pkg::key_t   key_q;
  shell_pkg::nonce_t nonce_q;
  logic              key_valid_d, key_valid_q;
  logic              req_d, req_q;

  // Key material
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= shell_pkg::KEY_DEFAULT;
      nonce_q <= shell_pkg::NONCE_DEFAULT;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  ///////////////////////////////////////////////////
  // Request and valid state
  ///////////////////////////////////////////////////

  assign req_d       = req_q ? ~scramble_key_valid_i : inval_i;
  assign key_valid_d = req_q   ? scramble_key_valid_i :
                       inval_i ? 1'b0                 :
                                 key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = key_valid_q;
  assign key_o          = key_q;
  assign nonce_o        = nonce_q;

endmodule

`default_nettype wire

// ==== src/scr_ram.sv ====
// Single-port scrambled RAM, one-cycle read latency.
// Pad is key ^ nonce ^ word index; a rekey leaves old contents unreadable
// as plaintext. No reset on the array or the read register.
`timescale 1ns/1ns
`default_nettype none

module scr_ram (
  input  logic                 clk_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  shell_pkg::be_t       be_i,
  input  shell_pkg::ram_addr_t addr_i,
  input  shell_pkg::word_t     wdata_i,
  input  shell_pkg::key_t      key_i,
  input  shell_pkg::nonce_t    nonce_i,
  output shell_pkg::word_t     rdata_o
);

  shell_pkg::word_t mem [shell_pkg::RAM_WORDS];
  shell_pkg::word_t pad;
  shell_pkg::word_t rdata_q;

  // Keystream for the addressed word
  assign pad = shell_pkg::word_t'(key_i) ^ shell_pkg::word_t'(nonce_i) ^
               shell_pkg::word_t'(addr_i);

  ///////////////////////////////////////////////////
  // Write, per byte
  ///////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < shell_pkg::BE_W; b++) begin
        if (be_i[b]) begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8] ^ pad[8*b +: 8];
        end
      end
    end
  end

  ///////////////////////////////////////////////////
  // Read
  ///////////////////////////////////////////////////

  // Descrambled with the key present at the read
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem[addr_i] ^ pad;
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== src/shell_pkg.sv ====
// Shared widths, types and reset constants for the memory shell.
// RAM word index is taken from address bits 9:2, so higher bits alias.
`default_nettype none

package shell_pkg;

  ///////////////////////////////////////////////////
  // Widths
  ///////////////////////////////////////////////////

  localparam int unsigned DATA_W     = 32;
  localparam int unsigned BE_W       = DATA_W / 8;
  localparam int unsigned RAM_WORDS  = 256;
  localparam int unsigned RAM_AW     = $clog2(RAM_WORDS);
  localparam int unsigned KEY_W      = 32;
  localparam int unsigned NONCE_W    = 32;
  localparam int unsigned IRQ_FAST_W = 15;

  ///////////////////////////////////////////////////
  // Types
  ///////////////////////////////////////////////////

  typedef logic [DATA_W-1:0]  word_t;
  typedef logic [31:0]        addr_t;
  typedef logic [BE_W-1:0]    be_t;
  typedef logic [RAM_AW-1:0]  ram_addr_t;
  typedef logic [KEY_W-1:0]   key_t;
  typedef logic [NONCE_W-1:0] nonce_t;

  // Key material in use until the first fresh key arrives
  localparam key_t   KEY_DEFAULT   = 32'h9e37_79b9;
  localparam nonce_t NONCE_DEFAULT = 32'h5a5a_3c3c;

endpackage

`default_nettype wire

// ==== src/wake_ctrl.sv ====
// Sleep indication from the registered busy flag, debug and interrupts.
// Interrupt and debug lines act without delay; busy acts one cycle late.
`timescale 1ns/1ns
`default_nettype none

module wake_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              core_busy_i,
  input  logic                              debug_req_i,
  input  logic                              irq_software_i,
  input  logic                              irq_timer_i,
  input  logic                              irq_external_i,
  input  logic [shell_pkg::IRQ_FAST_W-1:0]  irq_fast_i,
  input  logic                              irq_nm_i,
  output logic                              core_sleep_o
);

  logic core_busy_q;
  logic irq_pending;
  logic wake;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  assign irq_pending  = irq_software_i | irq_timer_i | irq_external_i | (|irq_fast_i);
  assign wake         = core_busy_q | debug_req_i | irq_pending | irq_nm_i;
  assign core_sleep_o = ~wake;

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// Testbench clock and reset, 100 ns period.
// Reset is held low for 4 rising edges and released on a falling edge.
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/tb_core_shell.sv ====
// Testbench for the memory shell; it plays the core on both ports.
// Only words written earlier are read back, the RAM has no reset value.
// Inputs change on the falling edge and outputs are sampled 10 ns later.
`timescale 1ns/1ns
`default_nettype none

module tb_core_shell;

  localparam int TIMEOUT = 50;
  localparam int SETTLE  = 10;
  localparam int N_MEM   = 10;
  localparam int N_WAKE  = 11;

  typedef struct packed {
    logic             we;
    shell_pkg::be_t   be;
    shell_pkg::addr_t addr;
  } mem_op_t;

  typedef struct packed {
    logic                             busy;
    logic                             debug;
    logic                             sw;
    logic                             timer;
    logic                             ext;
    logic [shell_pkg::IRQ_FAST_W-1:0] fast;
    logic                             nm;
    logic                             sleep;
  } wake_row_t;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             instr_req_i;
  shell_pkg::addr_t                 instr_addr_i;
  logic                             instr_gnt_o;
  logic                             instr_rvalid_o;
  shell_pkg::word_t                 instr_rdata_o;
  logic                             data_req_i;
  logic                             data_we_i;
  shell_pkg::be_t                   data_be_i;
  shell_pkg::addr_t                 data_addr_i;
  shell_pkg::word_t                 data_wdata_i;
  logic                             data_gnt_o;
  logic                             data_rvalid_o;
  shell_pkg::word_t                 data_rdata_o;
  logic                             inval_i;
  logic                             scramble_key_valid_i;
  shell_pkg::key_t                  scramble_key_i;
  shell_pkg::nonce_t                scramble_nonce_i;
  logic                             scramble_req_o;
  logic                             core_busy_i;
  logic                             debug_req_i;
  logic                             irq_software_i;
  logic                             irq_timer_i;
  logic                             irq_external_i;
  logic [shell_pkg::IRQ_FAST_W-1:0] irq_fast_i;
  logic                             irq_nm_i;
  logic                             core_sleep_o;

  // Model holds the expected plaintext and the key material in use
  shell_pkg::word_t  plain [shell_pkg::RAM_WORDS];
  shell_pkg::key_t   key_m;
  shell_pkg::nonce_t nonce_m;
  logic [31:0]       rng_state;
  mem_op_t           mem_ops [N_MEM];
  wake_row_t         wake_rows [N_WAKE];
  int                errors;
  int                checks;
  int                tests;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  core_shell_top UUT (.*);

  ///////////////////////////////////////////////////
  // Model and checks
  ///////////////////////////////////////////////////

  function automatic shell_pkg::word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic shell_pkg::ram_addr_t word_index(input shell_pkg::addr_t addr);
    return addr[shell_pkg::RAM_AW+1:2];
  endfunction

  function automatic shell_pkg::word_t pad_of(input shell_pkg::ram_addr_t idx,
                                              input shell_pkg::key_t key,
                                              input shell_pkg::nonce_t nonce);
    return key ^ nonce ^ shell_pkg::word_t'(idx);
  endfunction

  function automatic shell_pkg::word_t model_read(input shell_pkg::addr_t addr);
    return plain[word_index(addr)];
  endfunction

  task automatic model_write(input shell_pkg::addr_t addr, input shell_pkg::be_t be,
                             input shell_pkg::word_t wdata);
    shell_pkg::ram_addr_t idx;
    idx = word_index(addr);
    for (int b = 0; b < shell_pkg::BE_W; b++) begin
      if (be[b]) begin
        plain[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  // Old words now read as old plaintext ^ old pad ^ new pad
  task automatic rekey_model(input shell_pkg::key_t key, input shell_pkg::nonce_t nonce);
    shell_pkg::ram_addr_t idx;
    for (int i = 0; i < shell_pkg::RAM_WORDS; i++) begin
      idx        = shell_pkg::ram_addr_t'(i);
      plain[idx] = plain[idx] ^ pad_of(idx, key_m, nonce_m) ^ pad_of(idx, key, nonce);
    end
    key_m   = key;
    nonce_m = nonce;
  endtask

  task automatic check_word(input string name, input shell_pkg::word_t got,
                            input shell_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - err_start);
  endtask

  ///////////////////////////////////////////////////
  // Data port
  ///////////////////////////////////////////////////

  task automatic drive_data(input logic req, input logic we, input shell_pkg::be_t be,
                            input shell_pkg::addr_t addr, input shell_pkg::word_t wdata);
    data_req_i   = req;
    data_we_i    = we;
    data_be_i    = be;
    data_addr_i  = addr;
    data_wdata_i = wdata;
  endtask

  // Finishes the request already on the data port
  task automatic complete_data();
    int               n;
    logic             granted;
    shell_pkg::word_t exp;
    n = 0;
    #SETTLE;
    while (data_gnt_o !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk_i);
      #SETTLE;
      n++;
    end
    granted = (data_gnt_o === 1'b1);
    if (granted && data_we_i) begin
      model_write(data_addr_i, data_be_i, data_wdata_i);
    end
    exp = model_read(data_addr_i);
    @(negedge clk_i);
    data_req_i = 1'b0;
    if (!granted) begin
      $display("Data request to address %h was not granted in time", data_addr_i);
      errors++;
    end else begin
      #SETTLE;
      check_bit("data_rvalid_o", data_rvalid_o, 1'b1);
      if (!data_we_i) begin
        check_word("data_rdata_o", data_rdata_o, exp);
      end
    end
  endtask

  ///////////////////////////////////////////////////
  // Tests
  ///////////////////////////////////////////////////

  task automatic memory_test();
    shell_pkg::word_t wdata;
    for (int r = 0; r < N_MEM; r++) begin
      wdata = next_rand();
      @(negedge clk_i);
      drive_data(1'b1, mem_ops[r].we, mem_ops[r].be, mem_ops[r].addr, wdata);
      complete_data();
    end
  endtask

  task automatic arbitration_test();
    shell_pkg::word_t exp_d;
    shell_pkg::word_t exp_i;
    exp_d = model_read(32'h0000_0024);
    exp_i = model_read(32'h0000_03fc);
    @(negedge clk_i);
    drive_data(1'b1, 1'b0, 4'hf, 32'h0000_0024, 32'h0);
    instr_req_i  = 1'b1;
    instr_addr_i = 32'h0000_03fc;
    #SETTLE;
    check_bit("data_gnt_o", data_gnt_o, 1'b1);
    check_bit("instr_gnt_o", instr_gnt_o, 1'b0);
    @(negedge clk_i);
    data_req_i = 1'b0;
    #SETTLE;
    check_bit("data_rvalid_o", data_rvalid_o, 1'b1);
    check_word("data_rdata_o", data_rdata_o, exp_d);
    check_bit("instr_rvalid_o", instr_rvalid_o, 1'b0);
    check_bit("instr_gnt_o", instr_gnt_o, 1'b1);
    @(negedge clk_i);
    instr_req_i = 1'b0;
    #SETTLE;
    check_bit("instr_rvalid_o", instr_rvalid_o, 1'b1);
    check_word("instr_rdata_o", instr_rdata_o, exp_i);
    check_bit("data_rvalid_o", data_rvalid_o, 1'b0);
  endtask

  task automatic rekey_test();
    @(negedge clk_i);
    inval_i = 1'b1;
    @(negedge clk_i);
    inval_i = 1'b0;
    drive_data(1'b1, 1'b0, 4'hf, 32'h0000_0024, 32'h0);
    #SETTLE;
    check_bit("scramble_req_o", scramble_req_o, 1'b1);
    // Request must sit ungranted while the key is stale
    for (int c = 0; c < 5; c++) begin
      check_bit("data_gnt_o", data_gnt_o, 1'b0);
      @(negedge clk_i);
      #SETTLE;
    end
    @(negedge clk_i);
    scramble_key_i       = next_rand();
    scramble_nonce_i     = next_rand();
    scramble_key_valid_i = 1'b1;
    rekey_model(scramble_key_i, scramble_nonce_i);
    @(negedge clk_i);
    scramble_key_valid_i = 1'b0;
    #SETTLE;
    check_bit("scramble_req_o", scramble_req_o, 1'b0);
    complete_data();
  endtask

  task automatic wake_test();
    logic busy_prev;
    busy_prev = 1'b0;
    for (int r = 0; r < N_WAKE; r++) begin
      @(negedge clk_i);
      core_busy_i    = wake_rows[r].busy;
      debug_req_i    = wake_rows[r].debug;
      irq_software_i = wake_rows[r].sw;
      irq_timer_i    = wake_rows[r].timer;
      irq_external_i = wake_rows[r].ext;
      irq_fast_i     = wake_rows[r].fast;
      irq_nm_i       = wake_rows[r].nm;
      // Busy is registered, so give it one edge
      if (wake_rows[r].busy != busy_prev) begin
        @(negedge clk_i);
      end
      busy_prev = wake_rows[r].busy;
      #SETTLE;
      check_bit("core_sleep_o", core_sleep_o, wake_rows[r].sleep);
    end
  endtask

  initial begin : main_seq
    int n;
    int err_start;
    instr_req_i          = 1'b0;
    instr_addr_i         = 32'h0;
    drive_data(1'b0, 1'b0, 4'h0, 32'h0, 32'h0);
    inval_i              = 1'b0;
    scramble_key_valid_i = 1'b0;
    scramble_key_i       = 32'h0;
    scramble_nonce_i     = 32'h0;
    core_busy_i          = 1'b0;
    debug_req_i          = 1'b0;
    irq_software_i       = 1'b0;
    irq_timer_i          = 1'b0;
    irq_external_i       = 1'b0;
    irq_fast_i           = '0;
    irq_nm_i             = 1'b0;
    rng_state            = 32'hc67a_789c;
    key_m                = shell_pkg::KEY_DEFAULT;
    nonce_m              = shell_pkg::NONCE_DEFAULT;
    errors               = 0;
    checks               = 0;
    tests                = 0;

    // Full writes come first so no read sees an unwritten byte
    mem_ops = '{
      '{1'b1, 4'hf, 32'h0000_0010},
      '{1'b1, 4'hf, 32'h0000_0024},
      '{1'b1, 4'hf, 32'h0000_03fc},
      '{1'b0, 4'hf, 32'h0000_0010},
      '{1'b1, 4'h5, 32'h0000_0010},
      '{1'b1, 4'h8, 32'h0000_0024},
      '{1'b0, 4'hf, 32'h0000_0010},
      '{1'b0, 4'hf, 32'h0000_0024},
      '{1'b0, 4'hf, 32'h0000_03fc},
      '{1'b0, 4'hf, 32'h0000_0410}
    };

    // busy, debug, sw, timer, ext, fast, nm, expected sleep
    wake_rows = '{
      '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 15'h0000, 1'b0, 1'b1},
      '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 15'h0000, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 15'h0000, 1'b0, 1'b1},
      '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 15'h0000, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 15'h0000, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 15'h0000, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 15'h0000, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 15'h4000, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 15'h0001, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 15'h0000, 1'b1, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 15'h0000, 1'b0, 1'b1}
    };

    n = 0;
    while (rst_ni !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (rst_ni !== 1'b1) begin
      $display("Reset was never released");
      errors++;
    end

    err_start = errors;
    @(negedge clk_i);
    #SETTLE;
    check_bit("scramble_req_o", scramble_req_o, 1'b0);
    check_bit("data_rvalid_o", data_rvalid_o, 1'b0);
    check_bit("instr_rvalid_o", instr_rvalid_o, 1'b0);
    check_bit("core_sleep_o", core_sleep_o, 1'b1);
    finish_test("reset", err_start);

    err_start = errors;
    memory_test();
    finish_test("write and read-back", err_start);

    err_start = errors;
    arbitration_test();
    finish_test("arbitration", err_start);

    err_start = errors;
    rekey_test();
    finish_test("rekey", err_start);

    err_start = errors;
    wake_test();
    finish_test("wake", err_start);

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
